// File: rtl/rast_defines.svh
// Widths and constants shared by the rasterizer package and RTL
// Include wherever one of the macros is needed
`ifndef RAST_DEFINES_SVH
`define RAST_DEFINES_SVH

// Signed fixed-point coordinate
`define RAST_COORD_W 16
`define RAST_RADIX   4     // Fraction bits, one pixel is 16 units

// Packed color, carried through untouched
`define RAST_COLOR_W 24

// Vertices per triangle
`define RAST_VERTS   3

`endif

// File: rtl/rast_pkg.sv
// Types, enums and the grid step function for the triangle rasterizer
`include "rast_defines.svh"

package rast_pkg;

    typedef logic signed [`RAST_COORD_W-1:0] coord_t;
    typedef logic [`RAST_COLOR_W-1:0] color_t;
    typedef logic signed [2*`RAST_COORD_W+1:0] edge_t;   // Edge function value

    typedef enum logic [1:0] {
        SS_1X   = 2'd0,
        SS_2X   = 2'd1,
        SS_4X   = 2'd2,
        SS_RSVD = 2'd3     // Treated as SS_1X
    } subsample_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_WALK = 1'b1
    } iter_state_e;

    // Sample spacing in coordinate units
    function automatic coord_t sample_step(input subsample_e ss);
        case (ss)
            SS_2X:   return coord_t'(1 << (`RAST_RADIX - 1));
            SS_4X:   return coord_t'(1 << (`RAST_RADIX - 2));
            default: return coord_t'(1 << `RAST_RADIX);   // One sample per pixel
        endcase
    endfunction

endpackage

// File: rtl/rast_bbox.sv
// Accepts a triangle when not halted and registers its clipped bounding box
// Box, vertices and color are valid the cycle after acceptance
`timescale 1ns/1ps
`include "rast_defines.svh"

module rast_bbox (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tri_valid,
    input  rast_pkg::coord_t       v0_x,
    input  rast_pkg::coord_t       v0_y,
    input  rast_pkg::coord_t       v1_x,
    input  rast_pkg::coord_t       v1_y,
    input  rast_pkg::coord_t       v2_x,
    input  rast_pkg::coord_t       v2_y,
    input  rast_pkg::color_t       tri_color,
    input  rast_pkg::coord_t       screen_w,
    input  rast_pkg::coord_t       screen_h,
    input  rast_pkg::subsample_e   subsample,
    input  logic                   halt,
    output logic                   box_valid,
    output logic                   box_empty,
    output rast_pkg::coord_t       min_x,
    output rast_pkg::coord_t       min_y,
    output rast_pkg::coord_t       max_x,
    output rast_pkg::coord_t       max_y,
    output rast_pkg::coord_t       tv0_x,
    output rast_pkg::coord_t       tv0_y,
    output rast_pkg::coord_t       tv1_x,
    output rast_pkg::coord_t       tv1_y,
    output rast_pkg::coord_t       tv2_x,
    output rast_pkg::coord_t       tv2_y,
    output rast_pkg::color_t       box_color
);

    rast_pkg::coord_t vx [`RAST_VERTS];
    rast_pkg::coord_t vy [`RAST_VERTS];
    rast_pkg::coord_t lo_x, lo_y, hi_x, hi_y;
    rast_pkg::coord_t step, mask;
    rast_pkg::coord_t lim_x, lim_y;
    rast_pkg::coord_t clip_lo_x, clip_lo_y, clip_hi_x, clip_hi_y;
    logic             accept;

    assign vx = '{v0_x, v1_x, v2_x};
    assign vy = '{v0_y, v1_y, v2_y};

    assign accept = tri_valid & ~halt;   // Ignored while a walk is pending
    assign step   = rast_pkg::sample_step(subsample);
    assign mask   = ~(step - rast_pkg::coord_t'(1));   // Floors to the grid

    // Vertex extents
    always_comb begin
        lo_x = vx[0];
        hi_x = vx[0];
        lo_y = vy[0];
        hi_y = vy[0];
        for (int i = 1; i < `RAST_VERTS; i++) begin
            if (vx[i] < lo_x) lo_x = vx[i];
            if (vx[i] > hi_x) hi_x = vx[i];
            if (vy[i] < lo_y) lo_y = vy[i];
            if (vy[i] > hi_y) hi_y = vy[i];
        end
    end

    assign lim_x = screen_w - step;   // Last grid point on screen
    assign lim_y = screen_h - step;

    assign clip_lo_x = ((lo_x & mask) < 0) ? '0 : (lo_x & mask);
    assign clip_lo_y = ((lo_y & mask) < 0) ? '0 : (lo_y & mask);
    assign clip_hi_x = ((hi_x & mask) > lim_x) ? lim_x : (hi_x & mask);
    assign clip_hi_y = ((hi_y & mask) > lim_y) ? lim_y : (hi_y & mask);

    always_ff @(posedge clk) begin
        if (rst) begin
            box_valid <= 1'b0;
        end else begin
            box_valid <= accept;   // One cycle pulse
        end
    end

    // Held until the next acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            min_x     <= clip_lo_x;
            min_y     <= clip_lo_y;
            max_x     <= clip_hi_x;
            max_y     <= clip_hi_y;
            box_empty <= (clip_lo_x > clip_hi_x) || (clip_lo_y > clip_hi_y);
            tv0_x     <= v0_x;
            tv0_y     <= v0_y;
            tv1_x     <= v1_x;
            tv1_y     <= v1_y;
            tv2_x     <= v2_x;
            tv2_y     <= v2_y;
            box_color <= tri_color;
        end
    end

endmodule

// File: rtl/rast_iter_fsm.sv
// Walk control: starts a walk on each non-empty box and ends it on the last sample
// Halt covers the box cycle and the whole walk
`timescale 1ns/1ps

module rast_iter_fsm (
    input  logic clk,
    input  logic rst,
    input  logic box_valid,
    input  logic box_empty,
    input  logic last,
    output logic load,
    output logic advance,
    output logic sample_valid,
    output logic halt
);

    rast_pkg::iter_state_e state, state_nxt;

    assign load         = box_valid & ~box_empty & (state == rast_pkg::ST_IDLE);
    assign sample_valid = (state == rast_pkg::ST_WALK);   // One sample per cycle
    assign advance      = sample_valid & ~last;
    assign halt         = box_valid | (state != rast_pkg::ST_IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            rast_pkg::ST_IDLE: begin
                if (load) state_nxt = rast_pkg::ST_WALK;   // Empty boxes stay idle
            end
            rast_pkg::ST_WALK: begin
                if (last) state_nxt = rast_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rast_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// File: rtl/rast_sample_counter.sv
// Sample position counter, walks the box row by row at the grid step
// Last is high while the position sits on the box maximum
`timescale 1ns/1ps

module rast_sample_counter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  logic                 advance,
    input  rast_pkg::subsample_e subsample,
    input  rast_pkg::coord_t     min_x,
    input  rast_pkg::coord_t     min_y,
    input  rast_pkg::coord_t     max_x,
    input  rast_pkg::coord_t     max_y,
    output rast_pkg::coord_t     sample_x,
    output rast_pkg::coord_t     sample_y,
    output logic                 last
);

    rast_pkg::coord_t step;

    assign step = rast_pkg::sample_step(subsample);
    assign last = (sample_x == max_x) && (sample_y == max_y);

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_x <= '0;
            sample_y <= '0;
        end else if (load) begin
            sample_x <= min_x;   // Box corner
            sample_y <= min_y;
        end else if (advance) begin
            if (sample_x >= max_x) begin
                // End of row, back to the left edge
                sample_x <= min_x;
                sample_y <= sample_y + step;
            end else begin
                sample_x <= sample_x + step;
            end
        end
    end

endmodule

// File: rtl/rast_sample_test.sv
// Two-stage edge test, stage 1 evaluates the edge functions, stage 2 the sign rule
// A hit leaves exactly two cycles after its sample
`timescale 1ns/1ps
`include "rast_defines.svh"

module rast_sample_test (
    input  logic             clk,
    input  logic             rst,
    input  logic             sample_valid,
    input  rast_pkg::coord_t sample_x,
    input  rast_pkg::coord_t sample_y,
    input  rast_pkg::coord_t tv0_x,
    input  rast_pkg::coord_t tv0_y,
    input  rast_pkg::coord_t tv1_x,
    input  rast_pkg::coord_t tv1_y,
    input  rast_pkg::coord_t tv2_x,
    input  rast_pkg::coord_t tv2_y,
    input  rast_pkg::color_t box_color,
    output logic             hit_valid,
    output rast_pkg::coord_t hit_x,
    output rast_pkg::coord_t hit_y,
    output rast_pkg::color_t hit_color
);

    rast_pkg::coord_t vx [`RAST_VERTS];
    rast_pkg::coord_t vy [`RAST_VERTS];
    rast_pkg::edge_t  edge_c [`RAST_VERTS];
    rast_pkg::edge_t  s1_edge [`RAST_VERTS];
    logic             s1_valid;
    rast_pkg::coord_t s1_x, s1_y;
    rast_pkg::color_t s1_color;
    logic             all_pos, all_neg;

    assign vx = '{tv0_x, tv1_x, tv2_x};
    assign vy = '{tv0_y, tv1_y, tv2_y};

    // Edge i runs from vertex i to vertex i+1
    always_comb begin
        rast_pkg::edge_t dx, dy, px, py;
        int n;
        for (int i = 0; i < `RAST_VERTS; i++) begin
            n  = (i + 1) % `RAST_VERTS;
            dx = rast_pkg::edge_t'(vx[n]) - rast_pkg::edge_t'(vx[i]);
            dy = rast_pkg::edge_t'(vy[n]) - rast_pkg::edge_t'(vy[i]);
            px = rast_pkg::edge_t'(sample_x) - rast_pkg::edge_t'(vx[i]);
            py = rast_pkg::edge_t'(sample_y) - rast_pkg::edge_t'(vy[i]);
            edge_c[i] = dx * py - dy * px;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) s1_valid <= 1'b0;
        else     s1_valid <= sample_valid;
    end

    always_ff @(posedge clk) begin
        s1_edge  <= edge_c;
        s1_x     <= sample_x;
        s1_y     <= sample_y;
        s1_color <= box_color;   // Color travels with its sample
    end

    // Strictly inside for either winding, on-edge samples miss
    always_comb begin
        all_pos = 1'b1;
        all_neg = 1'b1;
        for (int i = 0; i < `RAST_VERTS; i++) begin
            all_pos = all_pos & (s1_edge[i] > 0);
            all_neg = all_neg & (s1_edge[i] < 0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) hit_valid <= 1'b0;
        else     hit_valid <= s1_valid & (all_pos | all_neg);
    end

    always_ff @(posedge clk) begin
        hit_x     <= s1_x;
        hit_y     <= s1_y;
        hit_color <= s1_color;
    end

endmodule

// File: rtl/rast_top.sv
// Triangle rasterizer top, one triangle at a time in, one hit per cycle out
// Hold tri_valid off while halt is high, a triangle offered then is dropped
`timescale 1ns/1ps

module rast_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tri_valid,
    input  rast_pkg::coord_t     v0_x,
    input  rast_pkg::coord_t     v0_y,
    input  rast_pkg::coord_t     v1_x,
    input  rast_pkg::coord_t     v1_y,
    input  rast_pkg::coord_t     v2_x,
    input  rast_pkg::coord_t     v2_y,
    input  rast_pkg::color_t     tri_color,
    input  rast_pkg::coord_t     screen_w,
    input  rast_pkg::coord_t     screen_h,
    input  rast_pkg::subsample_e subsample,
    output logic                 halt,
    output logic                 hit_valid,
    output rast_pkg::coord_t     hit_x,
    output rast_pkg::coord_t     hit_y,
    output rast_pkg::color_t     hit_color
);

    logic             box_valid, box_empty;
    rast_pkg::coord_t min_x, min_y, max_x, max_y;
    rast_pkg::coord_t tv0_x, tv0_y, tv1_x, tv1_y, tv2_x, tv2_y;
    rast_pkg::color_t box_color;
    logic             load, advance, sample_valid, last;
    rast_pkg::coord_t sample_x, sample_y;

    rast_bbox u_bbox (
        .clk       (clk),       .rst       (rst),
        .tri_valid (tri_valid),
        .v0_x      (v0_x),      .v0_y      (v0_y),
        .v1_x      (v1_x),      .v1_y      (v1_y),
        .v2_x      (v2_x),      .v2_y      (v2_y),
        .tri_color (tri_color),
        .screen_w  (screen_w),  .screen_h  (screen_h),
        .subsample (subsample), .halt      (halt),
        .box_valid (box_valid), .box_empty (box_empty),
        .min_x     (min_x),     .min_y     (min_y),
        .max_x     (max_x),     .max_y     (max_y),
        .tv0_x     (tv0_x),     .tv0_y     (tv0_y),
        .tv1_x     (tv1_x),     .tv1_y     (tv1_y),
        .tv2_x     (tv2_x),     .tv2_y     (tv2_y),
        .box_color (box_color)
    );

    rast_iter_fsm u_iter_fsm (
        .clk          (clk),          .rst       (rst),
        .box_valid    (box_valid),    .box_empty (box_empty),
        .last         (last),         .load      (load),
        .advance      (advance),      .sample_valid (sample_valid),
        .halt         (halt)
    );

    rast_sample_counter u_sample_counter (
        .clk      (clk),      .rst      (rst),
        .load     (load),     .advance  (advance),
        .subsample (subsample),
        .min_x    (min_x),    .min_y    (min_y),
        .max_x    (max_x),    .max_y    (max_y),
        .sample_x (sample_x), .sample_y (sample_y),
        .last     (last)
    );

    rast_sample_test u_sample_test (
        .clk          (clk),          .rst       (rst),
        .sample_valid (sample_valid),
        .sample_x     (sample_x),     .sample_y  (sample_y),
        .tv0_x        (tv0_x),        .tv0_y     (tv0_y),
        .tv1_x        (tv1_x),        .tv1_y     (tv1_y),
        .tv2_x        (tv2_x),        .tv2_y     (tv2_y),
        .box_color    (box_color),
        .hit_valid    (hit_valid),
        .hit_x        (hit_x),        .hit_y     (hit_y),
        .hit_color    (hit_color)
    );

endmodule

// File: tb/rast_clkgen.sv
// Free running testbench clock with a 4 ns period
`timescale 1ns/1ps

module rast_clkgen (
    output logic clk
);

    initial clk = 1'b0;
    always #2 clk = ~clk;   // Half period

endmodule

// File: tb/rast_sva.sv
// Assertions on acceptance, reset and walk bounds
// Bound into rast_top at the end of this file
`timescale 1ns/1ps

module rast_sva (
    input logic             clk, rst, tri_valid, box_valid, hit_valid, sample_valid,
    input rast_pkg::coord_t sample_x, sample_y, min_x, min_y, max_x, max_y
);

    // A new box never lands inside a running walk
    a_accept: assert property (@(posedge clk) disable iff (rst)
        box_valid |-> ($past(tri_valid) && !$past(sample_valid) && !sample_valid))
        else $error("triangle accepted while a walk was running");

    a_reset_quiet: assert property (@(posedge clk) rst |=> !hit_valid)
        else $error("hit_valid high after a reset cycle");

    a_walk_bounds: assert property (@(posedge clk) disable iff (rst)
        sample_valid |-> (sample_x >= min_x && sample_x <= max_x &&
                          sample_y >= min_y && sample_y <= max_y))
        else $error("sample (%0d, %0d) outside the box", sample_x, sample_y);

endmodule

bind rast_top rast_sva u_sva (
    .clk          (clk),          .rst       (rst),
    .tri_valid    (tri_valid),
    .box_valid    (box_valid),    .hit_valid (hit_valid),
    .sample_valid (sample_valid),
    .sample_x     (sample_x),     .sample_y  (sample_y),
    .min_x        (min_x),        .min_y     (min_y),
    .max_x        (max_x),        .max_y     (max_y)
);

// File: tb/rast_tb.sv
// Testbench for the triangle rasterizer that checks every hit against a reference list
// Random and directed triangles on an 8x8 pixel screen at all three sample grids
`timescale 1ns/1ps

module rast_tb;

    logic                 clk, rst, tri_valid, halt, hit_valid;
    rast_pkg::coord_t     v0_x, v0_y, v1_x, v1_y, v2_x, v2_y, hit_x, hit_y;
    rast_pkg::coord_t     screen_w, screen_h;
    rast_pkg::color_t     tri_color, hit_color;
    rast_pkg::subsample_e subsample;
    rast_pkg::coord_t     exp_x[$], exp_y[$];   // Expected hits, oldest first
    rast_pkg::color_t     exp_c[$];
    string                test_name = "reset";
    int                   hit_cnt = 0, mismatches = 0, stray = 0;
    int                   count_errs = 0, failures = 0;

    rast_clkgen u_clkgen (.clk(clk));
    rast_top UUT (.*);

    function automatic int snap(int v, int step);   // Floor to a multiple of step
        return v - (((v % step) + step) % step);
    endfunction

    function automatic int min3(int a, int b, int c);
        return (a < b) ? ((a < c) ? a : c) : ((b < c) ? b : c);
    endfunction

    function automatic int max3(int a, int b, int c);
        return (a > b) ? ((a > c) ? a : c) : ((b > c) ? b : c);
    endfunction

    // Reference rasterizer, pushes the expected hits in walk order
    function automatic int expected_hits(int ax, ay, bx, by, cx, cy,
                                         rast_pkg::color_t c, rast_pkg::subsample_e ss);
        int vx[3], vy[3], e[3];
        int step, lo_x, lo_y, hi_x, hi_y, cnt;
        vx = '{ax, bx, cx};
        vy = '{ay, by, cy};
        step = (ss == rast_pkg::SS_2X) ? 8 : (ss == rast_pkg::SS_4X) ? 4 : 16;
        lo_x = snap(min3(ax, bx, cx), step);
        lo_x = (lo_x < 0) ? 0 : lo_x;
        lo_y = snap(min3(ay, by, cy), step);
        lo_y = (lo_y < 0) ? 0 : lo_y;
        hi_x = snap(max3(ax, bx, cx), step);
        hi_x = (hi_x > int'(screen_w) - step) ? int'(screen_w) - step : hi_x;
        hi_y = snap(max3(ay, by, cy), step);
        hi_y = (hi_y > int'(screen_h) - step) ? int'(screen_h) - step : hi_y;
        cnt = 0;
        for (int sy = lo_y; sy <= hi_y; sy += step) begin
            for (int sx = lo_x; sx <= hi_x; sx += step) begin
                for (int i = 0; i < 3; i++) begin
                    e[i] = (vx[(i + 1) % 3] - vx[i]) * (sy - vy[i])
                         - (vy[(i + 1) % 3] - vy[i]) * (sx - vx[i]);
                end
                if ((e[0] > 0 && e[1] > 0 && e[2] > 0) ||
                    (e[0] < 0 && e[1] < 0 && e[2] < 0)) begin
                    exp_x.push_back(rast_pkg::coord_t'(sx));
                    exp_y.push_back(rast_pkg::coord_t'(sy));
                    exp_c.push_back(c);
                    cnt++;
                end
            end
        end
        return cnt;
    endfunction

    task automatic check_coord(string name, rast_pkg::coord_t exp, rast_pkg::coord_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_color(string name, rast_pkg::color_t exp, rast_pkg::color_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %06h, actual %06h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            $display("mismatch %s hit count: expected %0d, actual %0d", name, exp, act);
            count_errs++;
        end
    endtask

    // Hits sampled mid cycle where they are stable
    always @(negedge clk) begin
        if (!rst && hit_valid) begin
            hit_cnt++;
            if (exp_x.size() == 0) begin
                $display("%s: unexpected hit at (%0d, %0d)", test_name, hit_x, hit_y);
                stray++;
            end else begin
                check_coord({test_name, " hit_x"}, exp_x.pop_front(), hit_x);
                check_coord({test_name, " hit_y"}, exp_y.pop_front(), hit_y);
                check_color({test_name, " hit_color"}, exp_c.pop_front(), hit_color);
            end
        end
    end

    // One triangle, optionally followed by a second one offered while halted
    task automatic run_triangle(string name, int ax, ay, bx, by, cx, cy,
                                rast_pkg::color_t c, rast_pkg::subsample_e ss, bit intrude);
        int exp_n, base, n;
        test_name = name;
        exp_x.delete();
        exp_y.delete();
        exp_c.delete();
        exp_n = expected_hits(ax, ay, bx, by, cx, cy, c, ss);
        base = hit_cnt;
        @(negedge clk);
        v0_x = rast_pkg::coord_t'(ax);
        v0_y = rast_pkg::coord_t'(ay);
        v1_x = rast_pkg::coord_t'(bx);
        v1_y = rast_pkg::coord_t'(by);
        v2_x = rast_pkg::coord_t'(cx);
        v2_y = rast_pkg::coord_t'(cy);
        tri_color = c;
        subsample = ss;
        tri_valid = 1'b1;
        @(negedge clk);
        tri_valid = 1'b0;
        if (intrude) begin
            tri_color = ~c;   // Would show as wrong colors or extra hits
            tri_valid = 1'b1;
            @(negedge clk);
            tri_valid = 1'b0;
        end
        n = 0;
        while (halt !== 1'b0 && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (halt !== 1'b0) begin
            $display("%s: halt stayed high for %0d cycles", name, n);
            failures++;
        end
        repeat (3) @(negedge clk);   // Hits trail their samples by two cycles
        check_count(name, exp_n, hit_cnt - base);
    endtask

    initial begin
        int lo, hi;
        int r[6];
        rst = 1'b1;
        tri_valid = 1'b0;
        {v0_x, v0_y, v1_x, v1_y, v2_x, v2_y} = '0;
        tri_color = '0;
        screen_w = rast_pkg::coord_t'(128);   // 8 pixels of 16 units
        screen_h = rast_pkg::coord_t'(128);
        subsample = rast_pkg::SS_1X;
        void'($urandom(54061));
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            if (halt !== 1'b0 || hit_valid !== 1'b0) begin
                $display("halt or hit_valid is not low after reset with no triangle sent");
                failures++;
            end
        end
        run_triangle("winding_a", 16, 16, 100, 24, 40, 110, 24'h3366cc, rast_pkg::SS_1X, 1'b0);
        run_triangle("winding_b", 16, 16, 40, 110, 100, 24, 24'hcc6633, rast_pkg::SS_2X, 1'b0);
        for (int m = 0; m < 3; m++) begin
            for (int k = 0; k < 8; k++) begin
                lo = (k < 6) ? 0 : -48;   // Last two reach past the screen edges
                hi = (k < 6) ? 127 : 175;
                for (int i = 0; i < 6; i++) r[i] = lo + int'($urandom_range(hi - lo));
                run_triangle($sformatf("random_%0d_%0d", m, k), r[0], r[1], r[2], r[3],
                             r[4], r[5], rast_pkg::color_t'($urandom()),
                             rast_pkg::subsample_e'(m), 1'b0);
            end
        end
        run_triangle("clip", -40, -40, 200, 20, 30, 190, 24'h0f0f0f, rast_pkg::SS_4X, 1'b0);
        run_triangle("off_right", 200, 10, 240, 30, 220, 90, 24'h123456, rast_pkg::SS_1X, 1'b0);
        run_triangle("off_left", -90, -20, -20, -60, -50, -10, 24'h654321, rast_pkg::SS_2X, 1'b0);
        run_triangle("halt_ignore", 8, 8, 120, 16, 40, 120, 24'haa5500, rast_pkg::SS_1X, 1'b1);
        $display("Errors: %0d hit mismatches, %0d count mismatches, %0d stray hits, %0d other",
                 mismatches, count_errs, stray, failures);
        if (mismatches + count_errs + stray + failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+rtl
rtl/rast_pkg.sv
rtl/rast_bbox.sv
rtl/rast_iter_fsm.sv
rtl/rast_sample_counter.sv
rtl/rast_sample_test.sv
rtl/rast_top.sv
tb/rast_clkgen.sv
tb/rast_sva.sv
tb/rast_tb.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the rasterizer testbench
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -f compile.f --top-module rast_tb -o rast_sim &&
    ./obj_dir/rast_sim | tee /dev/stderr | grep -q "^Verification passed$" &&
    echo "PASS" || { echo "FAIL"; exit 1; }
